/* Bender.yml */
package:
  name: cyclic_buffer

sources:
  - files:
      - rtl/cbuf_pkg.sv
      - rtl/cbuf_store.sv
      - rtl/cbuf_fetch.sv
      - rtl/cbuf_out_fifo.sv
      - rtl/cbuf_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cbuf_tb.sv

/* cyclic_buffer.f */
+incdir+sim
rtl/cbuf_pkg.sv
rtl/cbuf_store.sv
rtl/cbuf_fetch.sv
rtl/cbuf_out_fifo.sv
rtl/cbuf_top.sv
sim/cbuf_tb.sv

/* rtl/cbuf_fetch.sv */
`timescale 1ns/1ps
module cbuf_fetch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clken,
  input  cbuf_pkg::cbuf_cfg_t    cfg,
  input  logic                   restart,
  input  logic                   pop,
  output cbuf_pkg::cbuf_rd_req_t rd_req
);

  cbuf_pkg::r_addr_t r_addr;
  cbuf_pkg::r_addr_t r_addr_next;
  logic              r_last;

  // Words requested and not yet popped from the FIFO
  cbuf_pkg::cnt_t    credit;
  cbuf_pkg::cnt_t    credit_next;
  logic              has_room;
  logic              issue;

  assign has_room = (credit < cbuf_pkg::CNT_W'(cbuf_pkg::FIFO_DEPTH));
  assign issue    = clken && !restart && has_room;

  // Window wrap back to the lower bound
  assign r_last      = (r_addr == cfg.r_addr_max);
  assign r_addr_next = r_last ? cfg.r_addr_min : r_addr + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_addr <= '0;
    end else if (restart) begin
      r_addr <= cfg.r_addr_min;
    end else if (issue) begin
      r_addr <= r_addr_next;
    end
  end

  // Issue and pop may land in the same cycle
  always_comb begin
    credit_next = credit;
    if (issue) begin
      credit_next = credit_next + 1'b1;
    end
    if (pop) begin
      credit_next = credit_next - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit <= '0;
    end else if (restart) begin
      credit <= '0;
    end else begin
      credit <= credit_next;
    end
  end

  assign rd_req.en   = issue;
  assign rd_req.addr = r_addr;

endmodule

/* rtl/cbuf_out_fifo.sv */
`timescale 1ns/1ps
module cbuf_out_fifo (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clken,
  input  logic              restart,
  input  cbuf_pkg::r_data_t rd_data,
  input  logic              rd_data_en,
  input  logic              r_en,
  output cbuf_pkg::r_data_t m_data,
  output logic              m_valid,
  output logic              pop
);

  cbuf_pkg::r_data_t   mem [cbuf_pkg::FIFO_DEPTH];
  cbuf_pkg::fifo_ptr_t wr_ptr;
  cbuf_pkg::fifo_ptr_t rd_ptr;
  cbuf_pkg::cnt_t      count;
  logic                push;

  // Fetch credits guarantee a free slot for every arriving word
  assign push = clken && rd_data_en;
  assign pop  = clken && r_en && m_valid;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rd_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (restart) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == cbuf_pkg::FIFO_PTR_W'(cbuf_pkg::FIFO_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == cbuf_pkg::FIFO_PTR_W'(cbuf_pkg::FIFO_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head entry is shown as soon as it is stored
  assign m_valid = (count != '0);
  assign m_data  = mem[rd_ptr];

endmodule

/* rtl/cbuf_pkg.sv */
package cbuf_pkg;

  // Geometry of the cyclic RAM
  localparam int R_DEPTH    = 64;
  localparam int R_DATA_W   = 8;
  localparam int W_DATA_W   = 32;
  localparam int W_DEPTH    = (R_DEPTH * R_DATA_W) / W_DATA_W;
  localparam int R_ADDR_W   = $clog2(R_DEPTH);
  localparam int W_ADDR_W   = $clog2(W_DEPTH);

  // RAM read latency in enabled cycles
  localparam int RD_LATENCY = 3;

  // Output FIFO must hold every word in flight plus one
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  typedef logic [R_ADDR_W-1:0]   r_addr_t;
  typedef logic [W_ADDR_W-1:0]   w_addr_t;
  typedef logic [R_DATA_W-1:0]   r_data_t;
  typedef logic [W_DATA_W-1:0]   w_data_t;
  typedef logic [CNT_W-1:0]      cnt_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  typedef struct packed {
    logic    en;
    w_data_t data;
  } cbuf_wr_t;

  typedef struct packed {
    w_addr_t w_addr_max;
    r_addr_t r_addr_max;
    r_addr_t r_addr_min;
  } cbuf_cfg_t;

  typedef struct packed {
    logic    en;
    r_addr_t addr;
  } cbuf_rd_req_t;

endpackage

/* rtl/cbuf_store.sv */
`timescale 1ns/1ps
module cbuf_store (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clken,
  input  cbuf_pkg::cbuf_wr_t     wr,
  input  cbuf_pkg::w_addr_t      w_addr_max,
  input  logic                   restart,
  input  cbuf_pkg::cbuf_rd_req_t rd_req,
  output cbuf_pkg::r_data_t      rd_data,
  output logic                   rd_data_en
);

  cbuf_pkg::w_addr_t w_addr;
  cbuf_pkg::w_addr_t w_addr_next;
  logic              w_last;

  cbuf_pkg::w_data_t mem [cbuf_pkg::W_DEPTH];

  cbuf_pkg::w_addr_t rd_word_addr;
  logic [cbuf_pkg::R_ADDR_W-cbuf_pkg::W_ADDR_W-1:0] rd_lane;
  logic [cbuf_pkg::R_ADDR_W-cbuf_pkg::W_ADDR_W-1:0] lane_q;
  cbuf_pkg::w_data_t word_q;
  cbuf_pkg::r_data_t byte_sel;

  cbuf_pkg::r_data_t data_pipe [1:cbuf_pkg::RD_LATENCY-1];
  logic [cbuf_pkg::RD_LATENCY-1:0] en_pipe;

  // Write pointer wraps at the run-time limit
  assign w_last      = (w_addr == w_addr_max);
  assign w_addr_next = w_last ? '0 : w_addr + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_addr <= '0;
    end else if (clken && wr.en) begin
      w_addr <= w_addr_next;
    end
  end

  // Byte k of word a sits at read address 4a + k
  assign rd_word_addr = rd_req.addr[cbuf_pkg::R_ADDR_W-1 -: cbuf_pkg::W_ADDR_W];
  assign rd_lane      = rd_req.addr[cbuf_pkg::R_ADDR_W-cbuf_pkg::W_ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (clken && wr.en) begin
      mem[w_addr] <= wr.data;
    end
  end

  // First stage is the read-before-write RAM output register
  always_ff @(posedge clk) begin
    if (clken) begin
      word_q <= mem[rd_word_addr];
      lane_q <= rd_lane;
    end
  end

  assign byte_sel = word_q[lane_q*cbuf_pkg::R_DATA_W +: cbuf_pkg::R_DATA_W];

  // Remaining stages carry the selected byte
  always_ff @(posedge clk) begin
    if (clken) begin
      data_pipe[1] <= byte_sel;
      for (int i = 2; i < cbuf_pkg::RD_LATENCY; i++) begin
        data_pipe[i] <= data_pipe[i-1];
      end
    end
  end

  // Strobe follows the data; restart drops reads still in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_pipe <= '0;
    end else if (restart) begin
      en_pipe <= '0;
    end else if (clken) begin
      en_pipe <= {en_pipe[cbuf_pkg::RD_LATENCY-2:0], rd_req.en};
    end
  end

  assign rd_data    = data_pipe[cbuf_pkg::RD_LATENCY-1];
  assign rd_data_en = en_pipe[cbuf_pkg::RD_LATENCY-1];

endmodule

/* rtl/cbuf_top.sv */
`timescale 1ns/1ps
module cbuf_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clken,
  input  cbuf_pkg::cbuf_wr_t  wr,
  input  cbuf_pkg::cbuf_cfg_t cfg,
  input  logic                restart,
  input  logic                r_en,
  output cbuf_pkg::r_data_t   m_data,
  output logic                m_valid
);

  cbuf_pkg::cbuf_rd_req_t rd_req;
  cbuf_pkg::r_data_t      rd_data;
  logic                   rd_data_en;
  logic                   pop;

  // Issues RAM reads ahead while FIFO credit remains
  cbuf_fetch fetch_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clken   (clken),
    .cfg     (cfg),
    .restart (restart),
    .pop     (pop),
    .rd_req  (rd_req)
  );

  cbuf_store store_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .wr         (wr),
    .w_addr_max (cfg.w_addr_max),
    .restart    (restart),
    .rd_req     (rd_req),
    .rd_data    (rd_data),
    .rd_data_en (rd_data_en)
  );

  // Absorbs the read latency so m_valid stays up under back-pressure
  cbuf_out_fifo fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .restart    (restart),
    .rd_data    (rd_data),
    .rd_data_en (rd_data_en),
    .r_en       (r_en),
    .m_data     (m_data),
    .m_valid    (m_valid),
    .pop        (pop)
  );

endmodule

/* sim/cbuf_tb_tasks.svh */
// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h80200003;
  end
  return s >> 1;
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    v    = {v[30:0], lfsr[0]};
    lfsr = lfsr_next(lfsr);
  end
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  end
endtask

task automatic close_test(input string name, input int errs_at_start);
  tests_run++;
  if (errors == errs_at_start) begin
    $display("%-16s ok", name);
  end else begin
    tests_failed++;
    $display("%-16s %0d error(s)", name, errors - errs_at_start);
  end
endtask

// Advance one cycle to just after the rising edge
task automatic step();
  @(posedge clk);
  #1;
endtask

function automatic int next_addr(input int a);
  if (a == int'(cfg.r_addr_max)) begin
    return int'(cfg.r_addr_min);
  end
  return a + 1;
endfunction

task automatic write_word(input logic [31:0] data);
  wr.en   = 1'b1;
  wr.data = data;
  step();
  wr.en   = 1'b0;
  for (int k = 0; k < 4; k++) begin
    ram_model[4 * w_ptr_model + k] = data[8 * k +: 8];
  end
  w_ptr_model = (w_ptr_model == int'(cfg.w_addr_max)) ? 0 : w_ptr_model + 1;
endtask

task automatic restart_read();
  r_en    = 1'b0;
  restart = 1'b1;
  step();
  restart = 1'b0;
  exp_addr = int'(cfg.r_addr_min);
endtask

// Wait for a word and pop it once it matches the model
task automatic pop_expect(input string tag);
  int waited;
  waited = 0;
  r_en   = 1'b1;
  while (!m_valid && waited < WAIT_LIMIT) begin
    step();
    waited++;
  end
  if (!m_valid) begin
    $display("Timeout in %s: no valid data for read address %0d", tag, exp_addr);
    errors++;
  end else begin
    check($sformatf("m_data[%0d]", exp_addr), m_data, ram_model[exp_addr]);
    exp_addr = next_addr(exp_addr);
    step();
  end
endtask

task automatic reset_state_test();
  int errs;
  errs  = errors;
  rst_n = 1'b0;
  clken = 1'b0;
  repeat (2) begin
    step();
    check("m_valid", m_valid, 0);
  end
  rst_n = 1'b1;
  repeat (2) begin
    step();
    check("m_valid", m_valid, 0);
  end
  clken = 1'b1;
  close_test("reset state", errs);
endtask

task automatic full_range_test();
  int          errs;
  logic [31:0] v;
  errs           = errors;
  cfg.w_addr_max = 4'd15;
  cfg.r_addr_min = 6'd0;
  cfg.r_addr_max = 6'd63;
  for (int i = 0; i < 16; i++) begin
    draw_bits(32, v);
    write_word(v);
  end
  restart_read();
  // 64 bytes and 8 more that wrap back to address 0
  for (int i = 0; i < 72; i++) begin
    pop_expect("full range");
  end
  r_en = 1'b0;
  close_test("full range", errs);
endtask

task automatic narrow_window_test();
  int errs;
  errs           = errors;
  cfg.r_addr_min = 6'd10;
  cfg.r_addr_max = 6'd17;
  restart_read();
  for (int i = 0; i < 30; i++) begin
    pop_expect("narrow window");
  end
  r_en = 1'b0;
  close_test("narrow window", errs);
endtask

task automatic back_pressure_test();
  int                errs;
  int                pops;
  logic [31:0]       v;
  logic              was_held;
  cbuf_pkg::r_data_t held;
  errs           = errors;
  pops           = 0;
  was_held       = 1'b0;
  held           = '0;
  cfg.r_addr_min = 6'd0;
  cfg.r_addr_max = 6'd63;
  restart_read();
  for (int c = 0; c < 200; c++) begin
    // A word left unpopped must still be there
    if (was_held) begin
      check("m_valid", m_valid, 1);
      check("m_data", m_data, held);
    end
    draw_bits(1, v);
    r_en     = v[0];
    was_held = m_valid && !r_en;
    held     = m_data;
    if (r_en && m_valid) begin
      check($sformatf("m_data[%0d]", exp_addr), m_data, ram_model[exp_addr]);
      exp_addr = next_addr(exp_addr);
      pops++;
    end
    step();
  end
  r_en = 1'b0;
  if (pops == 0) begin
    $display("Back-pressure test popped no data in 200 cycles");
    errors++;
  end
  close_test("back-pressure", errs);
endtask

task automatic write_wrap_test();
  int          errs;
  logic [31:0] v;
  errs           = errors;
  cfg.w_addr_max = 4'd3;
  // Words 4 and 5 land on addresses 0 and 1 again
  for (int i = 0; i < 6; i++) begin
    draw_bits(32, v);
    write_word(v);
  end
  cfg.r_addr_min = 6'd0;
  cfg.r_addr_max = 6'd15;
  restart_read();
  for (int i = 0; i < 16; i++) begin
    pop_expect("write wrap");
  end
  r_en = 1'b0;
  close_test("write wrap", errs);
endtask

task automatic clken_freeze_test();
  int                errs;
  int                waited;
  cbuf_pkg::r_data_t held;
  errs   = errors;
  waited = 0;
  r_en   = 1'b0;
  while (!m_valid && waited < WAIT_LIMIT) begin
    step();
    waited++;
  end
  if (!m_valid) begin
    $display("Timeout in clken freeze: no valid data before freezing");
    errors++;
  end
  held = m_data;
  check($sformatf("m_data[%0d]", exp_addr), held, ram_model[exp_addr]);
  clken = 1'b0;
  r_en  = 1'b1;
  repeat (10) begin
    step();
    check("m_valid", m_valid, 1);
    check("m_data", m_data, held);
  end
  clken = 1'b1;
  for (int i = 0; i < 8; i++) begin
    pop_expect("clken freeze");
  end
  r_en = 1'b0;
  close_test("clken freeze", errs);
endtask

/* sim/cbuf_tb.sv */
`timescale 1ns/1ps
module cbuf_tb;

  localparam int WAIT_LIMIT = 64;

  logic                clk;
  logic                rst_n;
  logic                clken;
  cbuf_pkg::cbuf_wr_t  wr;
  cbuf_pkg::cbuf_cfg_t cfg;
  logic                restart;
  logic                r_en;
  cbuf_pkg::r_data_t   m_data;
  logic                m_valid;

  // Byte view of the RAM
  cbuf_pkg::r_data_t ram_model [cbuf_pkg::R_DEPTH];
  int                w_ptr_model;
  int                exp_addr;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  cbuf_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clken   (clken),
    .wr      (wr),
    .cfg     (cfg),
    .restart (restart),
    .r_en    (r_en),
    .m_data  (m_data),
    .m_valid (m_valid)
  );

  always #5 clk = ~clk;

  `include "cbuf_tb_tasks.svh"

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    clken          = 1'b0;
    wr             = '0;
    cfg.w_addr_max = 4'd15;
    cfg.r_addr_max = 6'd63;
    cfg.r_addr_min = 6'd0;
    restart        = 1'b0;
    r_en           = 1'b0;
    lfsr           = 32'h04db219d;
    w_ptr_model    = 0;
    exp_addr       = 0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;

    reset_state_test();
    full_range_test();
    narrow_window_test();
    back_pressure_test();
    write_wrap_test();
    clken_freeze_test();

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
